//--- servile_pkg.sv
// Shared bus structs and register file constants for the servile memory subsystem
package servile_pkg;

   localparam int XLEN        = 32;
   localparam int REGS        = 32;
   localparam int REG_W       = 5;
   localparam int MUX_EXT_BIT = 31;

   // Bus request, held by the master until ack
   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic [XLEN-1:0] dat;
      logic [3:0]      sel;
      logic            we;
      logic            stb;
   } wb_req_t;

   // Bus response, ack high for one cycle
   typedef struct packed {
      logic [XLEN-1:0] rdt;
      logic            ack;
   } wb_rsp_t;

   // Serial write side of the core register port
   typedef struct packed {
      logic [REG_W-1:0] wreg0;
      logic [REG_W-1:0] wreg1;
      logic             wen0;
      logic             wen1;
      logic             wdata0;
      logic             wdata1;
   } rf_wr_t;

   // Source registers of a read transfer
   typedef struct packed {
      logic [REG_W-1:0] rreg0;
      logic [REG_W-1:0] rreg1;
   } rf_rd_req_t;

endpackage

//--- servile_mux.sv
// Data bus splitter, sends core accesses to main memory or the extension port
module servile_mux (
   input  servile_pkg::wb_req_t i_wb_cpu,
   output servile_pkg::wb_rsp_t o_wb_cpu,
   output servile_pkg::wb_req_t o_wb_mem,
   input  servile_pkg::wb_rsp_t i_wb_mem,
   output servile_pkg::wb_req_t o_wb_ext,
   input  servile_pkg::wb_rsp_t i_wb_ext
);

   logic ext_sel;

   // High half of the address space belongs to the extension port
   assign ext_sel = i_wb_cpu.adr[servile_pkg::MUX_EXT_BIT];

   always_comb begin
      o_wb_mem     = i_wb_cpu;
      o_wb_mem.stb = i_wb_cpu.stb & ~ext_sel;

      o_wb_ext     = i_wb_cpu;
      o_wb_ext.stb = i_wb_cpu.stb & ext_sel;
   end

   // Only the addressed slave answers the core
   always_comb begin
      if (ext_sel) begin
         o_wb_cpu.rdt = i_wb_ext.rdt;
         o_wb_cpu.ack = i_wb_ext.ack;
      end else begin
         o_wb_cpu.rdt = i_wb_mem.rdt;
         o_wb_cpu.ack = i_wb_mem.ack;
      end
   end

endmodule

//--- servile_arbiter.sv
// Memory port arbiter between instruction fetch and data access
module servile_arbiter (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  servile_pkg::wb_req_t i_wb_dbus,
   output servile_pkg::wb_rsp_t o_wb_dbus,
   input  servile_pkg::wb_req_t i_wb_ibus,
   output servile_pkg::wb_rsp_t o_wb_ibus,
   output servile_pkg::wb_req_t o_wb_mem,
   input  servile_pkg::wb_rsp_t i_wb_mem
);

   logic d_own;

   // Data access wins whenever it is pending
   assign d_own = i_wb_dbus.stb;

   always_comb begin
      o_wb_mem.adr = d_own ? i_wb_dbus.adr : i_wb_ibus.adr;
      o_wb_mem.dat = i_wb_dbus.dat;
      o_wb_mem.sel = i_wb_dbus.sel;
      o_wb_mem.we  = d_own & i_wb_dbus.we;
      o_wb_mem.stb = d_own | i_wb_ibus.stb;

      o_wb_dbus.rdt = i_wb_mem.rdt;
      o_wb_dbus.ack = i_wb_mem.ack & d_own;
      o_wb_ibus.rdt = i_wb_mem.rdt;
      o_wb_ibus.ack = i_wb_mem.ack & ~d_own;
   end

   // The core never fetches during a data access
   a_one_master: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !(i_wb_dbus.stb && i_wb_ibus.stb))
      else $error("Instruction and data strobes overlap");

endmodule

//--- rf_ram_ctrl.sv
// Register file SRAM sequencer for serial register reads and writes
module rf_ram_ctrl #(
   parameter int  rf_width = 8,
   localparam int AW       = $clog2(servile_pkg::REGS * 32 / rf_width)
) (
   input  logic                    i_clk,
   input  logic                    i_arst_n,
   input  logic                    i_rreq,
   input  logic                    i_wreq,
   input  servile_pkg::rf_rd_req_t i_rd,
   input  logic [4:0]              i_bit,
   input  logic                    i_last,
   output logic                    o_cnt_run,
   output logic                    o_wr_active,
   output logic                    o_ready,
   output logic [AW-1:0]           o_raddr,
   output logic                    o_ren,
   output logic                    o_load
);

   localparam int         PH_BITS   = $clog2(rf_width);
   localparam int         WPR       = 32 / rf_width;
   localparam logic [4:0] PH_LAST   = 5'(rf_width - 1);
   localparam logic [4:0] WORD_LAST = 5'(WPR - 1);

   typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_RD, ST_WR} state_t;

   state_t                        state;
   logic [1:0]                    step;
   logic                          wr_mode;
   servile_pkg::rf_rd_req_t       rd_q;
   logic [4:0]                    word;
   logic [4:0]                    phase;
   logic [4:0]                    widx;
   logic                          more;
   logic                          fetch0;
   logic                          fetch1;
   logic                          pre_rd;
   logic [servile_pkg::REG_W-1:0] rreg;

   assign word  = i_bit >> PH_BITS;
   assign phase = i_bit & PH_LAST;

   // Next word is fetched during phases 0 and 1 of the current one
   assign more   = (state == ST_RD) && (word < WORD_LAST);
   assign fetch0 = more && (phase == 5'd0);
   assign fetch1 = more && (phase == 5'd1);
   assign pre_rd = (state == ST_PRE) && !wr_mode && (step != 2'd2);

   assign rreg    = ((pre_rd && step == 2'd0) || fetch0) ? rd_q.rreg0 : rd_q.rreg1;
   assign widx    = (state == ST_PRE) ? 5'd0 : word + 5'd1;
   assign o_raddr = AW'(rreg) * AW'(WPR) + AW'(widx);
   assign o_ren   = pre_rd || fetch0 || fetch1;

   // Both words of a pair are on hand two cycles into the fetch
   assign o_load = ((state == ST_PRE) && !wr_mode && (step == 2'd2))
                   || (more && (phase == 5'd2));

   assign o_ready     = (state == ST_PRE) && (step == 2'd2);
   assign o_cnt_run   = (state == ST_RD) || (state == ST_WR);
   assign o_wr_active = (state == ST_WR);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= ST_IDLE;
         step    <= 2'd0;
         wr_mode <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_rreq) begin
                  state   <= ST_PRE;
                  step    <= 2'd0;
                  wr_mode <= 1'b0;
               end else if (i_wreq) begin
                  // Writes only need the ready cycle
                  state   <= ST_PRE;
                  step    <= 2'd2;
                  wr_mode <= 1'b1;
               end
            end
            ST_PRE: begin
               step <= step + 2'd1;
               if (step == 2'd2) begin
                  state <= wr_mode ? ST_WR : ST_RD;
               end
            end
            default: begin
               if (i_last) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && i_rreq) begin
         rd_q <= i_rd;
      end
   end

   a_width_legal: assert property (@(posedge i_clk)
      rf_width inside {4, 8, 16, 32})
      else $error("Unsupported register file width");

   a_req_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_rreq || i_wreq) |-> (state == ST_IDLE))
      else $error("Register request during a transfer");

endmodule

//--- rf_bit_cnt.sv
// Bit position counter for a 32 cycle serial register transfer
module rf_bit_cnt #(
   parameter int rf_width = 8
) (
   input  logic       i_clk,
   input  logic       i_arst_n,
   input  logic       i_run,
   output logic [4:0] o_bit,
   output logic       o_last
);

   localparam logic [4:0] PH_LAST  = 5'(rf_width - 1);
   localparam logic [4:0] BIT_LAST = 5'(servile_pkg::XLEN - 1);

   // Wraps to 0 on the last bit, parks at 0 when idle
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_bit <= 5'd0;
      end else if (i_run) begin
         o_bit <= o_bit + 5'd1;
      end else begin
         o_bit <= 5'd0;
      end
   end

   assign o_last = (o_bit == BIT_LAST);

   // A transfer only ever stops at the end of an SRAM word
   a_stop_on_word: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $fell(i_run) |-> (($past(o_bit) & PH_LAST) == PH_LAST))
      else $error("Bit counter stopped inside a word");

endmodule

//--- rf_rdata_shift.sv
// Read data path, buffers SRAM words and shifts register bits out LSB first
module rf_rdata_shift #(
   parameter int rf_width = 8
) (
   input  logic                i_clk,
   input  logic                i_arst_n,
   input  logic [4:0]          i_bit,
   input  logic                i_load,
   input  logic [rf_width-1:0] i_rdata,
   output logic                o_rdata0,
   output logic                o_rdata1
);

   localparam logic [4:0] PH_LAST = 5'(rf_width - 1);

   logic [rf_width-1:0] rdata_q;
   logic [rf_width-1:0] pend0;
   logic [rf_width-1:0] pend1;
   logic [rf_width-1:0] sh0;
   logic [rf_width-1:0] sh1;
   logic [4:0]          phase;
   logic                pre_load;
   logic                boundary;

   assign phase    = i_bit & PH_LAST;
   assign boundary = (phase == PH_LAST);

   // Prefetch pair lands right on the first word boundary, counter still at 0
   assign pre_load = i_load && (i_bit == 5'd0);

   // rreg0 word arrived a cycle before rreg1 word
   always_ff @(posedge i_clk) begin
      rdata_q <= i_rdata;
      if (i_load) begin
         pend0 <= rdata_q;
         pend1 <= i_rdata;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sh0 <= '0;
         sh1 <= '0;
      end else if (pre_load) begin
         sh0 <= rdata_q;
         sh1 <= i_rdata;
      end else if (boundary) begin
         sh0 <= pend0;
         sh1 <= pend1;
      end else begin
         sh0 <= sh0 >> 1;
         sh1 <= sh1 >> 1;
      end
   end

   assign o_rdata0 = sh0[0];
   assign o_rdata1 = sh1[0];

endmodule

//--- rf_wdata_gather.sv
// Write data path, gathers serial register bits into SRAM words
module rf_wdata_gather #(
   parameter int  rf_width = 8,
   localparam int AW       = $clog2(servile_pkg::REGS * 32 / rf_width)
) (
   input  logic                i_clk,
   input  logic                i_arst_n,
   input  logic                i_active,
   input  logic [4:0]          i_bit,
   input  servile_pkg::rf_wr_t i_wr,
   output logic [AW-1:0]       o_waddr,
   output logic [rf_width-1:0] o_wdata,
   output logic                o_wen
);

   localparam int         PH_BITS = $clog2(rf_width);
   localparam int         WPR     = 32 / rf_width;
   localparam logic [4:0] PH_LAST = 5'(rf_width - 1);

   logic [rf_width-2:0] sr0;
   logic [rf_width-2:0] sr1;
   logic [rf_width-1:0] hold_data;
   logic [AW-1:0]       hold_addr;
   logic [AW-1:0]       addr0;
   logic [4:0]          word;
   logic                word_end;
   logic                wr0_now;
   logic                hold_v;

   assign word     = i_bit >> PH_BITS;
   assign word_end = i_active && ((i_bit & PH_LAST) == PH_LAST);
   assign addr0    = AW'(i_wr.wreg0) * AW'(WPR) + AW'(word);
   assign wr0_now  = word_end && i_wr.wen0;

   // Bits come in LSB first, last bit of the word still on the input
   always_ff @(posedge i_clk) begin
      if (i_active) begin
         sr0 <= {i_wr.wdata0, sr0[rf_width-2:1]};
         sr1 <= {i_wr.wdata1, sr1[rf_width-2:1]};
      end
      if (word_end) begin
         hold_data <= {i_wr.wdata1, sr1};
         hold_addr <= AW'(i_wr.wreg1) * AW'(WPR) + AW'(word);
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         hold_v <= 1'b0;
      end else begin
         hold_v <= word_end && i_wr.wen1;
      end
   end

   // wreg1 word goes out the cycle after the wreg0 word
   assign o_wen   = wr0_now || hold_v;
   assign o_waddr = hold_v ? hold_addr : addr0;
   assign o_wdata = hold_v ? hold_data : {i_wr.wdata0, sr0};

   a_no_collide: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !(wr0_now && hold_v))
      else $error("Register file write collision");

endmodule

//--- servile.sv
// Servile memory side, bus split, memory arbitration and register file SRAM port
module servile #(
   parameter int  rf_width = 8,
   localparam int AW       = $clog2(servile_pkg::REGS * 32 / rf_width)
) (
   input  logic                    i_clk,
   input  logic                    i_arst_n,

   input  servile_pkg::wb_req_t    i_wb_ibus,
   output servile_pkg::wb_rsp_t    o_wb_ibus,
   input  servile_pkg::wb_req_t    i_wb_dbus,
   output servile_pkg::wb_rsp_t    o_wb_dbus,

   output servile_pkg::wb_req_t    o_wb_mem,
   input  servile_pkg::wb_rsp_t    i_wb_mem,
   output servile_pkg::wb_req_t    o_wb_ext,
   input  servile_pkg::wb_rsp_t    i_wb_ext,

   input  logic                    i_rf_rreq,
   input  logic                    i_rf_wreq,
   input  servile_pkg::rf_rd_req_t i_rf_rd,
   input  servile_pkg::rf_wr_t     i_rf_wr,
   output logic                    o_rf_ready,
   output logic                    o_rf_rdata0,
   output logic                    o_rf_rdata1,

   output logic [AW-1:0]           o_rf_waddr,
   output logic [rf_width-1:0]     o_rf_wdata,
   output logic                    o_rf_wen,
   output logic [AW-1:0]           o_rf_raddr,
   output logic                    o_rf_ren,
   input  logic [rf_width-1:0]     i_rf_rdata
);

   servile_pkg::wb_req_t wb_dmem_req;
   servile_pkg::wb_rsp_t wb_dmem_rsp;
   logic [4:0]           rf_bit;
   logic                 rf_last;
   logic                 cnt_run;
   logic                 wr_active;
   logic                 rf_load;

   servile_mux mux (
      .i_wb_cpu (i_wb_dbus),
      .o_wb_cpu (o_wb_dbus),
      .o_wb_mem (wb_dmem_req),
      .i_wb_mem (wb_dmem_rsp),
      .o_wb_ext (o_wb_ext),
      .i_wb_ext (i_wb_ext)
   );

   servile_arbiter arbiter (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .i_wb_dbus (wb_dmem_req),
      .o_wb_dbus (wb_dmem_rsp),
      .i_wb_ibus (i_wb_ibus),
      .o_wb_ibus (o_wb_ibus),
      .o_wb_mem  (o_wb_mem),
      .i_wb_mem  (i_wb_mem)
   );

   rf_ram_ctrl #(.rf_width(rf_width)) rf_ctrl (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_rreq      (i_rf_rreq),
      .i_wreq      (i_rf_wreq),
      .i_rd        (i_rf_rd),
      .i_bit       (rf_bit),
      .i_last      (rf_last),
      .o_cnt_run   (cnt_run),
      .o_wr_active (wr_active),
      .o_ready     (o_rf_ready),
      .o_raddr     (o_rf_raddr),
      .o_ren       (o_rf_ren),
      .o_load      (rf_load)
   );

   rf_bit_cnt #(.rf_width(rf_width)) rf_cnt (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_run    (cnt_run),
      .o_bit    (rf_bit),
      .o_last   (rf_last)
   );

   rf_rdata_shift #(.rf_width(rf_width)) rf_rd (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_bit    (rf_bit),
      .i_load   (rf_load),
      .i_rdata  (i_rf_rdata),
      .o_rdata0 (o_rf_rdata0),
      .o_rdata1 (o_rf_rdata1)
   );

   rf_wdata_gather #(.rf_width(rf_width)) rf_wr (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_active (wr_active),
      .i_bit    (rf_bit),
      .i_wr     (i_rf_wr),
      .o_waddr  (o_rf_waddr),
      .o_wdata  (o_rf_wdata),
      .o_wen    (o_rf_wen)
   );

endmodule

//--- tb_servile.sv
// Directed testbench for servile with bus slave, SRAM models and core side driver tasks
module wb_slave_model #(
   parameter logic [31:0] KEY = 32'h0
) (
   input  logic                 i_clk,
   input  servile_pkg::wb_req_t i_req,
   output servile_pkg::wb_rsp_t o_rsp
);
   timeunit 1ns;
   timeprecision 1ps;

   servile_pkg::wb_req_t req;
   int                   wait_left;

   initial begin
      o_rsp     = '0;
      wait_left = 0;
   end

   // Ack 1 to 3 cycles after the strobe, with read data derived from the address
   always begin
      @(posedge i_clk);
      req = i_req;
      #2;
      if (o_rsp.ack) begin
         o_rsp.ack = 1'b0;
         wait_left = 0;
      end else if (req.stb) begin
         if (wait_left == 0) begin
            wait_left = $urandom_range(3, 1);
         end
         wait_left--;
         if (wait_left == 0) begin
            o_rsp.rdt = req.adr ^ KEY;
            o_rsp.ack = 1'b1;
         end
      end
   end
endmodule

module tb_servile;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          RF_W       = 8;
   localparam int          WPR        = 32 / RF_W;
   localparam int          AW         = $clog2(32 * 32 / RF_W);
   localparam int          MAX_CYCLES = 2000;
   localparam int          ACK_LIMIT  = 10;
   localparam logic [31:0] MEM_KEY    = 32'h1357_9bdf;
   localparam logic [31:0] EXT_KEY    = 32'hc0de_0042;

   logic                    i_clk;
   logic                    i_arst_n;
   servile_pkg::wb_req_t    i_wb_ibus;
   servile_pkg::wb_rsp_t    o_wb_ibus;
   servile_pkg::wb_req_t    i_wb_dbus;
   servile_pkg::wb_rsp_t    o_wb_dbus;
   servile_pkg::wb_req_t    o_wb_mem;
   servile_pkg::wb_rsp_t    i_wb_mem;
   servile_pkg::wb_req_t    o_wb_ext;
   servile_pkg::wb_rsp_t    i_wb_ext;
   logic                    i_rf_rreq;
   logic                    i_rf_wreq;
   servile_pkg::rf_rd_req_t i_rf_rd;
   servile_pkg::rf_wr_t     i_rf_wr;
   logic                    o_rf_ready;
   logic                    o_rf_rdata0;
   logic                    o_rf_rdata1;
   logic [AW-1:0]           o_rf_waddr;
   logic [RF_W-1:0]         o_rf_wdata;
   logic                    o_rf_wen;
   logic [AW-1:0]           o_rf_raddr;
   logic                    o_rf_ren;
   logic [RF_W-1:0]         i_rf_rdata;

   logic [RF_W-1:0]         sram [2**AW];
   logic [31:0]             reg_model [32];
   logic [AW+RF_W-1:0]      wr_log [$];
   logic                    in_write;
   int                      cycles;

   servile #(.rf_width(RF_W)) dut (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_wb_ibus   (i_wb_ibus),
      .o_wb_ibus   (o_wb_ibus),
      .i_wb_dbus   (i_wb_dbus),
      .o_wb_dbus   (o_wb_dbus),
      .o_wb_mem    (o_wb_mem),
      .i_wb_mem    (i_wb_mem),
      .o_wb_ext    (o_wb_ext),
      .i_wb_ext    (i_wb_ext),
      .i_rf_rreq   (i_rf_rreq),
      .i_rf_wreq   (i_rf_wreq),
      .i_rf_rd     (i_rf_rd),
      .i_rf_wr     (i_rf_wr),
      .o_rf_ready  (o_rf_ready),
      .o_rf_rdata0 (o_rf_rdata0),
      .o_rf_rdata1 (o_rf_rdata1),
      .o_rf_waddr  (o_rf_waddr),
      .o_rf_wdata  (o_rf_wdata),
      .o_rf_wen    (o_rf_wen),
      .o_rf_raddr  (o_rf_raddr),
      .o_rf_ren    (o_rf_ren),
      .i_rf_rdata  (i_rf_rdata)
   );

   wb_slave_model #(.KEY(MEM_KEY)) mem_slave (
      .i_clk (i_clk),
      .i_req (o_wb_mem),
      .o_rsp (i_wb_mem)
   );

   wb_slave_model #(.KEY(EXT_KEY)) ext_slave (
      .i_clk (i_clk),
      .i_req (o_wb_ext),
      .o_rsp (i_wb_ext)
   );

   initial begin
      i_clk = 1'b0;
      forever begin
         #10 i_clk = ~i_clk;
      end
   end

   function automatic logic [RF_W-1:0] sram_fill(int addr);
      return {addr[6:0], 1'b1} ^ 8'h3c;
   endfunction

   // SRAM with one cycle read latency and a log of all writes
   always begin
      logic          wen;
      logic          ren;
      logic          win;
      logic [AW-1:0] waddr;
      logic [AW-1:0] raddr;
      logic [RF_W-1:0] wdata;
      @(posedge i_clk);
      wen   = o_rf_wen;
      ren   = o_rf_ren;
      win   = in_write;
      waddr = o_rf_waddr;
      raddr = o_rf_raddr;
      wdata = o_rf_wdata;
      #2;
      if (ren) begin
         i_rf_rdata = sram[raddr];
      end
      if (wen) begin
         sram[waddr] = wdata;
         if (!win) begin
            abort_run("SRAM write strobe seen outside a write transfer");
         end
         wr_log.push_back({waddr, wdata});
      end
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("Testbench failed");
         $fatal(1);
      end
   end

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic next_cycle();
      @(posedge i_clk);
      #2;
   endtask

   task automatic fetch_instr(logic [31:0] adr);
      int waited;
      waited = 0;
      next_cycle();
      i_wb_ibus.adr = adr;
      i_wb_ibus.stb = 1'b1;
      forever begin
         @(negedge i_clk);
         check("o_wb_ext.stb", 0, o_wb_ext.stb);
         check("o_wb_mem.stb", 1, o_wb_mem.stb);
         check("o_wb_mem.adr", adr, o_wb_mem.adr);
         if (o_wb_ibus.ack) break;
         waited++;
         if (waited > ACK_LIMIT) abort_run("Instruction fetch got no ack");
         next_cycle();
      end
      check("o_wb_ibus.rdt", adr ^ MEM_KEY, o_wb_ibus.rdt);
      check("o_wb_dbus.ack", 0, o_wb_dbus.ack);
      next_cycle();
      i_wb_ibus.stb = 1'b0;
   endtask

   task automatic data_access(logic [31:0] adr, logic [31:0] dat, logic [3:0] sel,
                              logic we);
      int                   waited;
      logic                 ext;
      servile_pkg::wb_req_t req;
      waited = 0;
      ext    = adr[31];
      next_cycle();
      i_wb_dbus.adr = adr;
      i_wb_dbus.dat = dat;
      i_wb_dbus.sel = sel;
      i_wb_dbus.we  = we;
      i_wb_dbus.stb = 1'b1;
      forever begin
         @(negedge i_clk);
         req = ext ? o_wb_ext : o_wb_mem;
         check("o_wb_ext.stb", ext, o_wb_ext.stb);
         check("o_wb_mem.stb", !ext, o_wb_mem.stb);
         check("adr", adr, req.adr);
         check("dat", dat, req.dat);
         check("sel", sel, req.sel);
         check("we", we, req.we);
         if (o_wb_dbus.ack) break;
         waited++;
         if (waited > ACK_LIMIT) abort_run("Data access got no ack");
         next_cycle();
      end
      check("o_wb_dbus.rdt", adr ^ (ext ? EXT_KEY : MEM_KEY), o_wb_dbus.rdt);
      check("o_wb_ibus.ack", 0, o_wb_ibus.ack);
      next_cycle();
      i_wb_dbus.stb = 1'b0;
   endtask

   task automatic write_reg_pair(logic [4:0] r0, logic [4:0] r1, logic en0, logic en1,
                                 logic [31:0] val0, logic [31:0] val1);
      logic [AW+RF_W-1:0] exp_q [$];
      int                 n;
      n = 0;
      for (int w = 0; w < WPR; w++) begin
         if (en0) exp_q.push_back({AW'(r0 * WPR + w), val0[w*RF_W +: RF_W]});
         if (en1) exp_q.push_back({AW'(r1 * WPR + w), val1[w*RF_W +: RF_W]});
      end
      wr_log.delete();
      next_cycle();
      in_write  = 1'b1;
      i_rf_wreq = 1'b1;
      i_rf_wr   = '{wreg0: r0, wreg1: r1, wen0: en0, wen1: en1, wdata0: 1'b0, wdata1: 1'b0};
      @(negedge i_clk);
      check("o_rf_ready", 0, o_rf_ready);
      forever begin
         next_cycle();
         i_rf_wreq = 1'b0;
         n++;
         @(negedge i_clk);
         if (o_rf_ready) break;
         if (n > 8) abort_run("No ready pulse after write request");
      end
      check("write ready delay", 1, n);
      for (int k = 0; k < 32; k++) begin
         next_cycle();
         i_rf_wr.wdata0 = val0[k];
         i_rf_wr.wdata1 = val1[k];
         @(negedge i_clk);
         check("o_rf_ready", 0, o_rf_ready);
      end
      repeat (3) next_cycle();
      in_write = 1'b0;
      i_rf_wr  = '0;
      next_cycle();
      check("SRAM write count", exp_q.size(), wr_log.size());
      foreach (exp_q[i]) begin
         check("o_rf_waddr", exp_q[i][AW+RF_W-1:RF_W], wr_log[i][AW+RF_W-1:RF_W]);
         check("o_rf_wdata", exp_q[i][RF_W-1:0], wr_log[i][RF_W-1:0]);
      end
      if (en0) reg_model[r0] = val0;
      if (en1) reg_model[r1] = val1;
   endtask

   task automatic read_reg_pair(logic [4:0] r0, logic [4:0] r1);
      int n;
      n = 0;
      next_cycle();
      i_rf_rreq     = 1'b1;
      i_rf_rd.rreg0 = r0;
      i_rf_rd.rreg1 = r1;
      @(negedge i_clk);
      check("o_rf_ready", 0, o_rf_ready);
      forever begin
         next_cycle();
         i_rf_rreq = 1'b0;
         n++;
         @(negedge i_clk);
         if (o_rf_ready) break;
         if (n > 8) abort_run("No ready pulse after read request");
      end
      check("read ready delay", 3, n);
      // Both registers stream LSB first from the cycle after ready
      for (int k = 0; k < 32; k++) begin
         next_cycle();
         @(negedge i_clk);
         check("o_rf_rdata0", reg_model[r0][k], o_rf_rdata0);
         check("o_rf_rdata1", reg_model[r1][k], o_rf_rdata1);
         check("o_rf_ready", 0, o_rf_ready);
      end
   endtask

   task automatic fetch_sequence();
      fetch_instr(32'h0000_0000);
      fetch_instr(32'h0000_0104);
      fetch_instr(32'h7fff_fffc);
   endtask

   task automatic split_data_accesses();
      data_access(32'h0000_2000, 32'h0000_0000, 4'hf, 1'b0);
      data_access(32'h0000_2004, 32'hdead_beef, 4'h3, 1'b1);
      data_access(32'h8000_0010, 32'h0000_0000, 4'hf, 1'b0);
      data_access(32'h8000_0014, 32'h1234_5678, 4'hc, 1'b1);
      fetch_instr(32'h0000_0008);
      data_access(32'h7fff_fff0, 32'ha5a5_0f0f, 4'h1, 1'b1);
   endtask

   task automatic roundtrip_regs();
      logic [31:0] v0;
      logic [31:0] v1;
      v0 = $urandom();
      v1 = $urandom();
      write_reg_pair(5'd5, 5'd12, 1'b1, 1'b1, v0, v1);
      read_reg_pair(5'd5, 5'd12);
      read_reg_pair(5'd12, 5'd5);
   endtask

   task automatic ready_timing();
      read_reg_pair(5'd3, 5'd30);
      write_reg_pair(5'd31, 5'd0, 1'b1, 1'b1, $urandom(), $urandom());
      read_reg_pair(5'd0, 5'd31);
   endtask

   task automatic partial_write();
      write_reg_pair(5'd5, 5'd12, 1'b1, 1'b0, $urandom(), $urandom());
      read_reg_pair(5'd5, 5'd12);
   endtask

   initial begin
      int seed_dummy;
      seed_dummy = $urandom(32'h0a66_6925);
      cycles     = 0;
      in_write   = 1'b0;
      i_arst_n   = 1'b0;
      i_wb_ibus  = '0;
      i_wb_dbus  = '0;
      i_rf_rreq  = 1'b0;
      i_rf_wreq  = 1'b0;
      i_rf_rd    = '0;
      i_rf_wr    = '0;
      i_rf_rdata = '0;
      for (int a = 0; a < 2**AW; a++) begin
         sram[a] = sram_fill(a);
      end
      for (int r = 0; r < 32; r++) begin
         for (int w = 0; w < WPR; w++) begin
            reg_model[r][w*RF_W +: RF_W] = sram_fill(r * WPR + w);
         end
      end
      repeat (5) @(posedge i_clk);
      #2;
      i_arst_n = 1'b1;
      @(negedge i_clk);
      check("o_rf_ready", 0, o_rf_ready);
      check("o_rf_wen", 0, o_rf_wen);
      check("o_rf_ren", 0, o_rf_ren);
      check("o_wb_mem.stb", 0, o_wb_mem.stb);
      check("o_wb_ext.stb", 0, o_wb_ext.stb);
      fetch_sequence();
      split_data_accesses();
      roundtrip_regs();
      ready_timing();
      partial_write();
      repeat (4) next_cycle();
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- filelist.f
servile_pkg.sv
servile_mux.sv
servile_arbiter.sv
rf_ram_ctrl.sv
rf_bit_cnt.sv
rf_rdata_shift.sv
rf_wdata_gather.sv
servile.sv
tb_servile.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_servile
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
